// File: hw/execPkg.sv
`default_nettype none

package execPkg;

    localparam int XLEN = 32;
    localparam int SHAMT_W = $clog2(XLEN);
    localparam int ROB_SIZE = 16;
    localparam int ROB_IDX_W = $clog2(ROB_SIZE);
    localparam int SQN_W = ROB_IDX_W + 1; // entry index plus one wrap bit
    localparam int TAG_W = 6;
    localparam int OPC_W = 4;

    typedef enum logic {
        FU_INT,
        FU_DIV
    } FuncUnit;

    typedef enum logic [OPC_W-1:0] {
        ADD, SUB, AND, OR,
        XOR, SLT, SLL, SRL
    } AluOp;

    typedef enum logic [OPC_W-1:0] {
        DIVU,
        REMU
    } DivOp;

    typedef struct packed {
        FuncUnit fu;
        logic [OPC_W-1:0] opcode; // AluOp or DivOp depending on fu
        logic [XLEN-1:0] srcA;
        logic [XLEN-1:0] srcB;
        logic [TAG_W-1:0] tagDst;
    } IssueUOp;

    typedef struct packed {
        FuncUnit fu;
        logic [OPC_W-1:0] opcode;
        logic [XLEN-1:0] srcA;
        logic [XLEN-1:0] srcB;
        logic [TAG_W-1:0] tagDst;
        logic [SQN_W-1:0] sqN;
    } ExecUOp;

    typedef struct packed {
        logic valid;
        logic [SQN_W-1:0] sqN;
        logic [TAG_W-1:0] tagDst;
        logic [XLEN-1:0] result;
    } ResUOp;

    typedef struct packed {
        logic [SQN_W-1:0] sqN;
        logic [TAG_W-1:0] tagDst;
        logic [XLEN-1:0] result;
    } CommitUOp;

endpackage

`default_nettype wire

// File: hw/skidBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module skidBuffer #(
    parameter type T = logic
) (
    input wire clk,
    input wire rst,
    input wire inValid,
    output logic inReady,
    input wire T inData,
    output logic outValid,
    input wire outReady,
    output T outData
);

    logic started;
    logic mainValid;
    logic spareValid;
    T mainData;
    T spareData;
    logic inFire;
    logic mainFree;

    assign inReady = started && !spareValid; // only own state, never outReady
    assign inFire = inValid && inReady;
    assign mainFree = !mainValid || outReady;
    assign outValid = mainValid;
    assign outData = mainData;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            mainValid <= 1'b0;
            spareValid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (mainFree) begin
                mainValid <= spareValid || inFire; // spare drains first
                spareValid <= 1'b0;
            end else if (inFire) begin
                spareValid <= 1'b1; // output stalled, catch the in-flight word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mainFree) begin
            mainData <= spareValid ? spareData : inData;
        end else if (inFire) begin
            spareData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: hw/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input wire clk,
    input wire rst,
    input wire inValid,
    input wire execPkg::ExecUOp inUop,
    output execPkg::ResUOp result
);

    logic [execPkg::XLEN-1:0] aluOut;
    logic lessThan;
    logic [execPkg::SHAMT_W-1:0] shamt;
    logic validQ;
    logic [execPkg::SQN_W-1:0] sqNQ;
    logic [execPkg::TAG_W-1:0] tagQ;
    logic [execPkg::XLEN-1:0] valueQ;

    assign lessThan = $signed(inUop.srcA) < $signed(inUop.srcB);
    assign shamt = inUop.srcB[execPkg::SHAMT_W-1:0];

    always_comb begin
        case (inUop.opcode)
            execPkg::ADD: aluOut = inUop.srcA + inUop.srcB;
            execPkg::SUB: aluOut = inUop.srcA - inUop.srcB;
            execPkg::AND: aluOut = inUop.srcA & inUop.srcB;
            execPkg::OR: aluOut = inUop.srcA | inUop.srcB;
            execPkg::XOR: aluOut = inUop.srcA ^ inUop.srcB;
            execPkg::SLT: aluOut = {{(execPkg::XLEN-1){1'b0}}, lessThan};
            execPkg::SLL: aluOut = inUop.srcA << shamt;
            execPkg::SRL: aluOut = inUop.srcA >> shamt; // logical, zero fill
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            sqNQ <= inUop.sqN;
            tagQ <= inUop.tagDst;
            valueQ <= aluOut;
        end
    end

    // the result sits on the bus for exactly one cycle and always wins arbitration
    assign result = '{valid: validQ, sqN: sqNQ, tagDst: tagQ, result: valueQ};

endmodule

`default_nettype wire

// File: hw/divider.sv
`timescale 1ns/1ps
`default_nettype none

module divider (
    input wire clk,
    input wire rst,
    input wire inValid,
    input wire execPkg::ExecUOp inUop,
    output logic busy,
    output logic req,
    input wire grant,
    output execPkg::ResUOp result
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } State;

    State state;
    logic [execPkg::SHAMT_W-1:0] step;
    logic [execPkg::XLEN-1:0] quot;
    logic [execPkg::XLEN-1:0] rem;
    logic [execPkg::XLEN-1:0] divisor;
    logic [execPkg::XLEN:0] trial;
    logic isRem;
    logic start;
    logic [execPkg::SQN_W-1:0] sqNQ;
    logic [execPkg::TAG_W-1:0] tagQ;

    assign start = inValid && (state == IDLE);
    assign busy = (state != IDLE);
    assign req = (state == DONE);

    // shift the next dividend bit into the partial remainder and try the subtract
    assign trial = {rem, quot[execPkg::XLEN-1]} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            step <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        step <= '0;
                    end
                end
                RUN: begin
                    step <= step + 1'b1;
                    if (step == '1) begin
                        state <= DONE; // all 32 quotient bits resolved
                    end
                end
                DONE: begin
                    if (grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quot <= inUop.srcA; // dividend shifts out as quotient bits shift in
            rem <= '0;
            divisor <= inUop.srcB;
            isRem <= (inUop.opcode == execPkg::REMU);
            sqNQ <= inUop.sqN;
            tagQ <= inUop.tagDst;
        end else if (state == RUN) begin
            if (!trial[execPkg::XLEN]) begin
                rem <= trial[execPkg::XLEN-1:0];
                quot <= {quot[execPkg::XLEN-2:0], 1'b1};
            end else begin
                rem <= {rem[execPkg::XLEN-2:0], quot[execPkg::XLEN-1]};
                quot <= {quot[execPkg::XLEN-2:0], 1'b0};
            end
        end
    end

    // a zero divisor never fails the subtract, so the quotient ends all ones
    // and the remainder ends equal to the dividend
    assign result = '{
        valid: req,
        sqN: sqNQ,
        tagDst: tagQ,
        result: isRem ? rem : quot
    };

endmodule

`default_nettype wire

// File: hw/wbArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbArbiter (
    input wire execPkg::ResUOp aluResult,
    input wire divReq,
    input wire execPkg::ResUOp divResult,
    output logic divGrant,
    output execPkg::ResUOp wbBus
);

    logic aluWins;

    // the ALU cannot stall, so it owns the bus whenever it has a result
    assign aluWins = aluResult.valid;
    assign divGrant = divReq && !aluWins;

    always_comb begin
        if (aluWins) begin
            wbBus = aluResult;
        end else begin
            wbBus = divResult;
            wbBus.valid = divReq; // divider waits here until a free slot
        end
    end

endmodule

`default_nettype wire

// File: hw/reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer (
    input wire clk,
    input wire rst,
    input wire inValid,
    output logic inReady,
    input wire execPkg::IssueUOp inUop,
    input wire divBusy,
    output logic aluValid,
    output logic divValid,
    output execPkg::ExecUOp execUop,
    input wire execPkg::ResUOp wbBus,
    output logic comValid,
    input wire comReady,
    output execPkg::CommitUOp comUop
);

    logic [execPkg::SQN_W-1:0] head;
    logic [execPkg::SQN_W-1:0] tail;
    logic [execPkg::ROB_IDX_W-1:0] headIdx;
    logic [execPkg::ROB_IDX_W-1:0] tailIdx;
    logic [execPkg::ROB_IDX_W-1:0] wbIdx;
    logic [execPkg::ROB_SIZE-1:0] entValid;
    logic [execPkg::ROB_SIZE-1:0] entDone;
    logic [execPkg::TAG_W-1:0] entTag [execPkg::ROB_SIZE];
    logic [execPkg::XLEN-1:0] entResult [execPkg::ROB_SIZE];
    logic full;
    logic unitReady;
    logic accept;
    logic retire;

    assign headIdx = head[execPkg::ROB_IDX_W-1:0];
    assign tailIdx = tail[execPkg::ROB_IDX_W-1:0];
    assign wbIdx = wbBus.sqN[execPkg::ROB_IDX_W-1:0];

    // same index with different wrap bits means every entry is taken
    assign full = (headIdx == tailIdx) && (head[execPkg::ROB_IDX_W] != tail[execPkg::ROB_IDX_W]);
    assign unitReady = (inUop.fu == execPkg::FU_INT) || !divBusy;
    assign inReady = !full && unitReady;
    assign accept = inValid && inReady;

    assign aluValid = accept && (inUop.fu == execPkg::FU_INT);
    assign divValid = accept && (inUop.fu == execPkg::FU_DIV);
    assign execUop = '{
        fu: inUop.fu,
        opcode: inUop.opcode,
        srcA: inUop.srcA,
        srcB: inUop.srcB,
        tagDst: inUop.tagDst,
        sqN: tail // the tail pointer doubles as the sequence number
    };

    assign comValid = entValid[headIdx] && entDone[headIdx];
    assign retire = comValid && comReady;
    assign comUop = '{sqN: head, tagDst: entTag[headIdx], result: entResult[headIdx]};

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            entValid <= '0;
            entDone <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;
                entValid[tailIdx] <= 1'b1;
                entDone[tailIdx] <= 1'b0;
            end
            if (wbBus.valid) begin
                entDone[wbIdx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
                entValid[headIdx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wbBus.valid) begin
            entTag[wbIdx] <= wbBus.tagDst;
            entResult[wbIdx] <= wbBus.result;
        end
    end

endmodule

`default_nettype wire

// File: hw/execCluster.sv
`timescale 1ns/1ps
`default_nettype none

module execCluster (
    input wire clk,
    input wire rst,
    input wire issueValid,
    output logic issueReady,
    input wire execPkg::IssueUOp issueUop,
    output logic commitValid,
    input wire commitReady,
    output execPkg::CommitUOp commitUop
);

    logic bufValid;
    logic bufReady;
    execPkg::IssueUOp bufUop;
    logic aluValid;
    logic divValid;
    execPkg::ExecUOp execUop;
    logic divBusy;
    logic divReq;
    logic divGrant;
    execPkg::ResUOp aluResult;
    execPkg::ResUOp divResult;
    execPkg::ResUOp wbBus;
    logic comValid;
    logic comReady;
    execPkg::CommitUOp comUop;

    skidBuffer #(
        .T(execPkg::IssueUOp)
    ) issueBuf (
        .clk(clk),
        .rst(rst),
        .inValid(issueValid),
        .inReady(issueReady),
        .inData(issueUop),
        .outValid(bufValid),
        .outReady(bufReady),
        .outData(bufUop)
    );

    reorderBuffer rob (
        .clk(clk),
        .rst(rst),
        .inValid(bufValid),
        .inReady(bufReady),
        .inUop(bufUop),
        .divBusy(divBusy),
        .aluValid(aluValid),
        .divValid(divValid),
        .execUop(execUop),
        .wbBus(wbBus),
        .comValid(comValid),
        .comReady(comReady),
        .comUop(comUop)
    );

    intAlu alu (
        .clk(clk),
        .rst(rst),
        .inValid(aluValid),
        .inUop(execUop),
        .result(aluResult)
    );

    divider div (
        .clk(clk),
        .rst(rst),
        .inValid(divValid),
        .inUop(execUop),
        .busy(divBusy),
        .req(divReq),
        .grant(divGrant),
        .result(divResult)
    );

    wbArbiter arb (
        .aluResult(aluResult),
        .divReq(divReq),
        .divResult(divResult),
        .divGrant(divGrant),
        .wbBus(wbBus)
    );

    skidBuffer #(
        .T(execPkg::CommitUOp)
    ) commitBuf (
        .clk(clk),
        .rst(rst),
        .inValid(comValid),
        .inReady(comReady),
        .inData(comUop),
        .outValid(commitValid),
        .outReady(commitReady),
        .outData(commitUop)
    );

endmodule

`default_nettype wire

// File: test/execCluster_sva.sv
`timescale 1ns/1ps
`default_nettype none

module execCluster_sva (
    input wire clk,
    input wire rst,
    input wire issueValid,
    input wire issueReady,
    input wire execPkg::IssueUOp issueUop,
    input wire commitValid,
    input wire commitReady,
    input wire execPkg::CommitUOp commitUop,
    input wire divValid,
    input wire divBusy,
    input wire divReq,
    input wire execPkg::ResUOp divResult,
    input wire divGrant
);

    issueHold: assert property (@(posedge clk) disable iff (rst)
        issueValid && !issueReady |=> issueValid && $stable(issueUop))
        else $error("issue payload changed while waiting for ready");

    commitHold: assert property (@(posedge clk) disable iff (rst)
        commitValid && !commitReady |=> commitValid && $stable(commitUop))
        else $error("commit payload changed while waiting for ready");

    // the divider takes one op at a time and stays busy once it has one
    divIssue: assert property (@(posedge clk) disable iff (rst)
        divValid |=> divBusy)
        else $error("divider did not go busy after a divide was dispatched");

    // a divide result that lost arbitration waits unchanged for its slot
    wbHold: assert property (@(posedge clk) disable iff (rst)
        divReq && !divGrant |=> divReq && $stable(divResult))
        else $error("divider result dropped or changed before it was granted");

endmodule

bind execCluster execCluster_sva sva_i (
    .clk(clk),
    .rst(rst),
    .issueValid(issueValid),
    .issueReady(issueReady),
    .issueUop(issueUop),
    .commitValid(commitValid),
    .commitReady(commitReady),
    .commitUop(commitUop),
    .divValid(divValid),
    .divBusy(divBusy),
    .divReq(divReq),
    .divResult(divResult),
    .divGrant(divGrant)
);

`default_nettype wire

// File: test/execClusterTb.sv
`timescale 1ns/1ps
`default_nettype none

module execClusterTb;

    localparam int NUM_ROWS = 24;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 60 + 200;
    localparam int RESET_CYCLES = 16;
    localparam int STALL_CYCLES = 100;
    localparam int DRAIN_CYCLES = 8;

    typedef struct packed {
        execPkg::FuncUnit fu;
        logic [execPkg::OPC_W-1:0] opcode;
        logic [execPkg::XLEN-1:0] srcA;
        logic [execPkg::XLEN-1:0] srcB;
        logic [execPkg::TAG_W-1:0] tagDst;
        logic [execPkg::XLEN-1:0] expected;
    } Row;

    logic clk;
    logic rst;
    logic issueValid;
    logic issueReady;
    execPkg::IssueUOp issueUop;
    logic commitValid;
    logic commitReady;
    execPkg::CommitUOp commitUop;

    Row rows [NUM_ROWS];
    integer seed;
    int row;
    int commitCount;
    int valueErrors;
    int otherErrors;
    int cycles;
    int stallLeft;
    int acceptedInStall;
    logic fire;
    logic stallSeen;

    execCluster dut_i (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueReady(issueReady),
        .issueUop(issueUop),
        .commitValid(commitValid),
        .commitReady(commitReady),
        .commitUop(commitUop)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // row index is the expected sqN, results worked out by hand from the op rules
    task automatic fillTable();
        rows[0] = '{execPkg::FU_INT, execPkg::ADD, 32'h0000_1234, 32'h0000_0FFF, 6'd8, 32'h0000_2233};
        rows[1] = '{execPkg::FU_INT, execPkg::SUB, 32'h0000_0005, 32'h0000_0007, 6'd9, 32'hFFFF_FFFE};
        rows[2] = '{execPkg::FU_INT, execPkg::AND, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 6'd10, 32'h00F0_00F0};
        rows[3] = '{execPkg::FU_INT, execPkg::OR, 32'hF000_0000, 32'h0000_000F, 6'd11, 32'hF000_000F};
        rows[4] = '{execPkg::FU_INT, execPkg::XOR, 32'hAAAA_AAAA, 32'hFFFF_0000, 6'd12, 32'h5555_AAAA};
        rows[5] = '{execPkg::FU_INT, execPkg::SLT, 32'hFFFF_FFFB, 32'h0000_0003, 6'd13, 32'h0000_0001};
        rows[6] = '{execPkg::FU_INT, execPkg::SLL, 32'h0000_0003, 32'h0000_00FF, 6'd14, 32'h8000_0000};
        rows[7] = '{execPkg::FU_INT, execPkg::SRL, 32'h8000_0001, 32'h0000_001F, 6'd15, 32'h0000_0001};
        rows[8] = '{execPkg::FU_DIV, execPkg::DIVU, 32'd100, 32'd7, 6'd16, 32'd14};
        rows[9] = '{execPkg::FU_INT, execPkg::ADD, 32'h7FFF_FFFF, 32'h0000_0001, 6'd17, 32'h8000_0000};
        rows[10] = '{execPkg::FU_INT, execPkg::SLT, 32'h0000_0002, 32'hFFFF_FFFF, 6'd18, 32'h0};
        rows[11] = '{execPkg::FU_INT, execPkg::SUB, 32'h0000_0000, 32'h0000_0001, 6'd19, 32'hFFFF_FFFF};
        rows[12] = '{execPkg::FU_INT, execPkg::XOR, 32'h1234_5678, 32'h1234_5678, 6'd20, 32'h0};
        rows[13] = '{execPkg::FU_INT, execPkg::SLL, 32'h0000_0001, 32'h0000_0004, 6'd21, 32'h10};
        rows[14] = '{execPkg::FU_INT, execPkg::SRL, 32'hF000_0000, 32'h0000_001C, 6'd22, 32'hF};
        rows[15] = '{execPkg::FU_INT, execPkg::OR, 32'h0000_0000, 32'h0000_0000, 6'd23, 32'h0};
        rows[16] = '{execPkg::FU_INT, execPkg::AND, 32'hFFFF_FFFF, 32'h0000_FFFF, 6'd24, 32'hFFFF};
        rows[17] = '{execPkg::FU_INT, execPkg::ADD, 32'hFFFF_FFFF, 32'h0000_0002, 6'd25, 32'h1};
        rows[18] = '{execPkg::FU_INT, execPkg::SLT, 32'h8000_0000, 32'h7FFF_FFFF, 6'd26, 32'h1};
        rows[19] = '{execPkg::FU_DIV, execPkg::REMU, 32'd100, 32'd7, 6'd27, 32'd2};
        rows[20] = '{execPkg::FU_DIV, execPkg::DIVU, 32'h1234_5678, 32'h0, 6'd28, 32'hFFFF_FFFF};
        rows[21] = '{execPkg::FU_DIV, execPkg::REMU, 32'h1234_5678, 32'h0, 6'd29, 32'h1234_5678};
        rows[22] = '{execPkg::FU_DIV, execPkg::DIVU, 32'd5, 32'd9, 6'd30, 32'd0};
        rows[23] = '{execPkg::FU_DIV, execPkg::REMU, 32'd5, 32'd9, 6'd31, 32'd5};
    endtask

    always @(posedge clk) begin : commitMonitor
        Row expRow;
        logic [execPkg::SQN_W-1:0] expSqN;
        if (!rst && commitValid && commitReady) begin
            assert (commitCount < NUM_ROWS) else begin
                $display("extra commit of sqN %0d after every row had committed", commitUop.sqN);
                otherErrors++;
            end
            if (commitCount < NUM_ROWS) begin
                expRow = rows[commitCount];
                expSqN = commitCount[execPkg::SQN_W-1:0]; // sqN wraps mod 32
                assert (commitUop.sqN == expSqN && commitUop.tagDst == expRow.tagDst
                        && commitUop.result == expRow.expected) else begin
                    $display("ERR %0t: commit got sqN %0d tag %0d result %h, expected %0d %0d %h",
                             $time, commitUop.sqN, commitUop.tagDst, commitUop.result,
                             expSqN, expRow.tagDst, expRow.expected);
                    valueErrors++;
                end
            end
            commitCount++;
        end
    end

    initial begin
        seed = 54875;
        rst = 1'b1;
        issueValid = 1'b0;
        issueUop = '0;
        commitReady = 1'b0;
        row = 0;
        commitCount = 0;
        valueErrors = 0;
        otherErrors = 0;
        cycles = 0;
        stallLeft = STALL_CYCLES;
        acceptedInStall = 0;
        fire = 1'b0;
        stallSeen = 1'b0;
        fillTable();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (commitValid === 1'b0 && issueReady === 1'b0) else begin
                $display("commitValid or issueReady was high during reset");
                otherErrors++;
            end
        end
        rst = 1'b0;

        while (commitCount < NUM_ROWS && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (fire) begin
                row++;
            end
            // payload may only change once the previous one was taken
            if (!issueValid || fire) begin
                if (row < NUM_ROWS && ({$random(seed)} % 4) != 0) begin
                    issueValid = 1'b1;
                    issueUop = '{fu: rows[row].fu, opcode: rows[row].opcode,
                                 srcA: rows[row].srcA, srcB: rows[row].srcB,
                                 tagDst: rows[row].tagDst};
                end else begin
                    issueValid = 1'b0;
                end
            end
            fire = issueValid && issueReady; // ready is stable until the next rising edge
            if (stallLeft > 0) begin
                commitReady = 1'b0;
                stallLeft--;
                if (fire) begin
                    acceptedInStall++;
                end
                if (!issueReady && !stallSeen) begin
                    stallSeen = 1'b1;
                    assert (acceptedInStall <= execPkg::ROB_SIZE + 4) else begin
                        $display("issue port took %0d ops before back-pressure reached it",
                                 acceptedInStall);
                        otherErrors++;
                    end
                end
            end else begin
                commitReady = ({$random(seed)} % 4) != 0;
            end
        end

        assert (commitCount >= NUM_ROWS) else begin
            $display("timeout after %0d cycles with %0d of %0d rows committed",
                     cycles, commitCount, NUM_ROWS);
            otherErrors++;
        end
        issueValid = 1'b0;
        commitReady = 1'b1;
        repeat (DRAIN_CYCLES) @(negedge clk); // any late commit now shows up as an extra one
        assert (stallSeen) else begin
            $display("issueReady never fell while commits were held off");
            otherErrors++;
        end

        $display("errors: %0d wrong values, %0d other failures, %0d of %0d rows committed",
                 valueErrors, otherErrors, commitCount, NUM_ROWS);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/execPkg.sv
hw/skidBuffer.sv
hw/intAlu.sv
hw/divider.sv
hw/wbArbiter.sv
hw/reorderBuffer.sv
hw/execCluster.sv
test/execCluster_sva.sv
test/execClusterTb.sv

// File: Makefile
TOP = execClusterTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
